// ==== mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// widths fixed by the isa
`define MEM_WORD_W          32  // data word and byte address
`define MEM_REG_ADDR_W      5   // gpr index
`define MEM_SEL_W           4   // byte lanes per word
`define MEM_EXC_W           32  // raw exception flags from ex

// raw exception flag positions, lowest bit wins
`define MEM_EXC_SYSCALL_BIT 8
`define MEM_EXC_INVALID_BIT 9
`define MEM_EXC_TRAP_BIT    10
`define MEM_EXC_OVF_BIT     11
`define MEM_EXC_ERET_BIT    12

// cp0 fields
`define MEM_IM_LO           8   // status mask / cause pending, low bit
`define MEM_IM_HI           15  // status mask / cause pending, high bit
`define MEM_ST_IE           0   // global interrupt enable
`define MEM_ST_EXL          1   // exception level, blocks interrupts

`define MEM_RAM_TIMEOUT     64  // upper bound on ram ack latency, cycles

`endif

// ==== mem_isa_pkg.sv ====
`include "mem_cfg.svh"
`default_nettype none

package mem_isa_pkg;

    typedef logic [`MEM_WORD_W-1:0]     word_t;      // gpr and ram data word
    typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;  // destination gpr
    typedef logic [`MEM_SEL_W-1:0]      byte_sel_t;  // bit 3 = lowest byte address (msb)
    typedef logic [`MEM_EXC_W-1:0]      exc_flags_t; // raw flags collected up to ex

    // memory opcode as handed down by ex
    typedef enum logic [7:0] {
        NOP = 8'h00, // alu result passes through
        LB  = 8'h01, // byte, sign extended
        LBU = 8'h02, // byte, zero extended
        LH  = 8'h03, // half, sign extended
        LHU = 8'h04, // half, zero extended
        LW  = 8'h05,
        LL  = 8'h06, // load linked, sets llbit
        SB  = 8'h07,
        SH  = 8'h08,
        SW  = 8'h09,
        SC  = 8'h0a  // store conditional on llbit
    } mem_op_e;

    // final exception code towards cp0
    typedef enum logic [4:0] {
        NONE      = 5'd0,
        INTERRUPT = 5'd1,
        SYSCALL   = 5'd8,
        INVALID   = 5'd10,
        OVERFLOW  = 5'd12,
        TRAP      = 5'd13,
        ERET      = 5'd14
    } exc_code_e;

endpackage

`default_nettype wire

// ==== mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // operation from ex, held stable while req is high
    typedef struct packed {
        mem_isa_pkg::mem_op_e    op;        // memory opcode
        mem_isa_pkg::word_t      addr;      // byte address
        mem_isa_pkg::word_t      wdata;     // rt value for stores
        mem_isa_pkg::reg_addr_t  waddr;     // destination gpr
        logic                    reg_we;    // gpr write enable
        mem_isa_pkg::word_t      alu_res;   // result for non-loads
        mem_isa_pkg::exc_flags_t exc;       // raw exception flags
        mem_isa_pkg::word_t      inst_addr; // pc of the instruction
    } mem_op_t;

    // one command on the data ram port
    typedef struct packed {
        mem_isa_pkg::word_t     addr;  // byte address, low two bits cleared
        logic                   we;    // store
        mem_isa_pkg::byte_sel_t sel;   // big-endian lane enables
        mem_isa_pkg::word_t     wdata; // lane-replicated store data
    } ram_cmd_t;

    // result towards writeback
    typedef struct packed {
        mem_isa_pkg::reg_addr_t waddr;       // destination gpr
        logic                   reg_we;      // gpr write enable
        mem_isa_pkg::word_t     wdata;       // aligned load or alu result
        logic                   llbit_we;    // link bit update
        logic                   llbit_value; // new link bit
        mem_isa_pkg::exc_code_e exc_code;    // resolved exception
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== mem_exc_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"
`default_nettype none

module mem_exc_arbiter (
    input  mem_bus_pkg::mem_op_t   op_i,         // current operation
    input  mem_isa_pkg::word_t     cp0_status_i, // cp0 status
    input  mem_isa_pkg::word_t     cp0_cause_i,  // cp0 cause
    output mem_isa_pkg::exc_code_e exc_code_o    // final code
);

    logic irq_pend; // pending and unmasked
    logic irq_take; // interrupt actually taken

    assign irq_pend = |(cp0_cause_i[`MEM_IM_HI:`MEM_IM_LO]
                      & cp0_status_i[`MEM_IM_HI:`MEM_IM_LO]);

    // pc 0 means a bubble, never interrupted
    assign irq_take = (op_i.inst_addr != '0) && irq_pend
                      && !cp0_status_i[`MEM_ST_EXL] && cp0_status_i[`MEM_ST_IE];

    always_comb begin
        if (irq_take) begin
            exc_code_o = mem_isa_pkg::INTERRUPT; // external interrupt first
        end else if (op_i.exc[`MEM_EXC_SYSCALL_BIT]) begin
            exc_code_o = mem_isa_pkg::SYSCALL;
        end else if (op_i.exc[`MEM_EXC_INVALID_BIT]) begin
            exc_code_o = mem_isa_pkg::INVALID;   // reserved instruction
        end else if (op_i.exc[`MEM_EXC_TRAP_BIT]) begin
            exc_code_o = mem_isa_pkg::TRAP;
        end else if (op_i.exc[`MEM_EXC_OVF_BIT]) begin
            exc_code_o = mem_isa_pkg::OVERFLOW;  // arithmetic overflow
        end else if (op_i.exc[`MEM_EXC_ERET_BIT]) begin
            exc_code_o = mem_isa_pkg::ERET;
        end else begin
            exc_code_o = mem_isa_pkg::NONE;
        end
    end

endmodule

`default_nettype wire

// ==== mem_access_decode.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"
`default_nettype none

module mem_access_decode (
    input  mem_bus_pkg::mem_op_t   op_i,          // current operation
    input  logic                   llbit_i,       // current link bit
    input  mem_isa_pkg::exc_code_e exc_code_i,    // from the arbiter
    output mem_bus_pkg::ram_cmd_t  cmd_o,         // ram command
    output logic                   need_ram_o,    // issue the command
    output logic                   llbit_we_o,
    output logic                   llbit_value_o
);

    logic [1:0]             ofs;      // byte offset in word
    logic                   is_mem;   // op targets ram at all
    logic                   misalign; // half or word not aligned
    logic                   sc_fail;  // sc without a valid link
    mem_isa_pkg::byte_sel_t byte_sel;
    mem_isa_pkg::byte_sel_t half_sel;

    assign ofs      = op_i.addr[1:0];
    assign byte_sel = 4'b1000 >> ofs;               // offset 0 is the msb lane
    assign half_sel = ofs[1] ? 4'b0011 : 4'b1100;   // upper pair at offset 0

    always_comb begin
        cmd_o      = '0;
        cmd_o.addr = {op_i.addr[`MEM_WORD_W-1:2], 2'b00}; // word aligned
        is_mem     = 1'b1;
        misalign   = 1'b0;
        unique case (op_i.op)
            mem_isa_pkg::LB, mem_isa_pkg::LBU: begin
                cmd_o.sel = byte_sel;
            end
            mem_isa_pkg::LH, mem_isa_pkg::LHU: begin
                cmd_o.sel = half_sel;
                misalign  = ofs[0];
            end
            mem_isa_pkg::LW: begin
                cmd_o.sel = 4'b1111;
                misalign  = |ofs;
            end
            mem_isa_pkg::LL: begin
                cmd_o.sel = 4'b1111; // alignment not checked, as in the core
            end
            mem_isa_pkg::SB: begin
                cmd_o.we    = 1'b1;
                cmd_o.sel   = byte_sel;
                cmd_o.wdata = {4{op_i.wdata[7:0]}};  // same byte on every lane
            end
            mem_isa_pkg::SH: begin
                cmd_o.we    = 1'b1;
                cmd_o.sel   = half_sel;
                cmd_o.wdata = {2{op_i.wdata[15:0]}}; // low half on both pairs
                misalign    = ofs[0];
            end
            mem_isa_pkg::SW: begin
                cmd_o.we    = 1'b1;
                cmd_o.sel   = 4'b1111;
                cmd_o.wdata = op_i.wdata;
                misalign    = |ofs;
            end
            mem_isa_pkg::SC: begin
                cmd_o.we    = 1'b1;
                cmd_o.sel   = 4'b1111;
                cmd_o.wdata = op_i.wdata;
            end
            default: begin
                is_mem = 1'b0; // nop, alu result only
            end
        endcase
    end

    assign sc_fail = (op_i.op == mem_isa_pkg::SC) && !llbit_i;

    // excepted ops never reach ram, stores included
    assign need_ram_o = is_mem && !misalign && !sc_fail
                        && (exc_code_i == mem_isa_pkg::NONE);

    // ll links, a successful sc consumes the link
    assign llbit_we_o    = (op_i.op == mem_isa_pkg::LL)
                           || ((op_i.op == mem_isa_pkg::SC) && llbit_i);
    assign llbit_value_o = (op_i.op == mem_isa_pkg::LL);

endmodule

`default_nettype wire

// ==== mem_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_load_align (
    input  mem_bus_pkg::mem_op_t op_i,    // current operation
    input  mem_isa_pkg::word_t   rdata_i, // registered ram word
    input  logic                 llbit_i, // link bit for sc result
    output mem_isa_pkg::word_t   wdata_o  // value for the gpr
);

    logic [1:0]  ofs;    // byte offset in word
    logic [7:0]  lane_b; // addressed byte
    logic [15:0] lane_h; // addressed half

    assign ofs = op_i.addr[1:0];

    // big-endian, lowest address holds the msb
    always_comb begin
        unique case (ofs)
            2'd0:    lane_b = rdata_i[31:24];
            2'd1:    lane_b = rdata_i[23:16];
            2'd2:    lane_b = rdata_i[15:8];
            default: lane_b = rdata_i[7:0];
        endcase
    end

    assign lane_h = ofs[1] ? rdata_i[15:0] : rdata_i[31:16];

    always_comb begin
        unique case (op_i.op)
            mem_isa_pkg::LB: begin
                wdata_o = {{24{lane_b[7]}}, lane_b};            // sign extend
            end
            mem_isa_pkg::LBU: begin
                wdata_o = {24'b0, lane_b};
            end
            mem_isa_pkg::LH: begin
                wdata_o = ofs[0] ? '0 : {{16{lane_h[15]}}, lane_h}; // misaligned gives 0
            end
            mem_isa_pkg::LHU: begin
                wdata_o = ofs[0] ? '0 : {16'b0, lane_h};
            end
            mem_isa_pkg::LW: begin
                wdata_o = (ofs != 2'd0) ? '0 : rdata_i;
            end
            mem_isa_pkg::LL: begin
                wdata_o = rdata_i;
            end
            mem_isa_pkg::SC: begin
                wdata_o = {31'b0, llbit_i};                     // 1 on success
            end
            default: begin
                wdata_o = op_i.alu_res; // nop and plain stores
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_stage_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_ctrl (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  req_i,       // upstream four-phase req
    input  logic                  need_ram_i,  // from decode
    input  mem_bus_pkg::ram_cmd_t cmd_i,       // decoded command
    input  logic                  ram_ack_i,   // ram four-phase ack
    input  mem_isa_pkg::word_t    ram_rdata_i, // valid with ram_ack_i
    output logic                  ack_o,       // upstream ack, wb valid
    output logic                  ram_req_o,
    output mem_bus_pkg::ram_cmd_t ram_cmd_o,   // held for the whole access
    output mem_isa_pkg::word_t    rdata_o      // captured read word
);

    typedef enum logic [2:0] {
        IDLE,     // waiting for req
        RAM_REQ,  // ram_req high until ram ack
        RAM_DROP, // req dropped, wait for ram to release ack
        DONE,     // result settles
        HOLD_ACK  // ack high until upstream drops req
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic                  ack_q;
    mem_bus_pkg::ram_cmd_t cmd_q;
    mem_isa_pkg::word_t    rdata_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = need_ram_i ? RAM_REQ : DONE; // no-ram ops skip the port
                end
            end
            RAM_REQ: begin
                if (ram_ack_i) begin
                    state_d = RAM_DROP;
                end
            end
            RAM_DROP: begin
                if (!ram_ack_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = HOLD_ACK;
            end
            HOLD_ACK: begin
                if (ack_q && !req_i) begin
                    state_d = IDLE; // ack falls on the same edge
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= (state_q == HOLD_ACK) && req_i; // registered, glitch free
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && req_i) begin
            cmd_q <= cmd_i;
            if (!need_ram_i) begin
                rdata_q <= '0; // skipped loads extract from zero
            end
        end
        if ((state_q == RAM_REQ) && ram_ack_i) begin
            rdata_q <= ram_rdata_i;
        end
    end

    assign ack_o     = ack_q;
    assign ram_req_o = (state_q == RAM_REQ);
    assign ram_cmd_o = cmd_q;
    assign rdata_o   = rdata_q;

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  req_i,        // op_i valid
    input  mem_bus_pkg::mem_op_t  op_i,
    input  logic                  llbit_i,      // held outside the stage
    input  mem_isa_pkg::word_t    cp0_status_i,
    input  mem_isa_pkg::word_t    cp0_cause_i,
    input  logic                  ram_ack_i,
    input  mem_isa_pkg::word_t    ram_rdata_i,
    output logic                  ack_o,        // wb_o valid
    output mem_bus_pkg::mem_wb_t  wb_o,
    output logic                  ram_req_o,
    output mem_bus_pkg::ram_cmd_t ram_cmd_o
);

    mem_isa_pkg::exc_code_e exc_code;
    mem_bus_pkg::ram_cmd_t  cmd;
    logic                   need_ram;
    logic                   llbit_we;
    logic                   llbit_value;
    mem_isa_pkg::word_t     rdata;      // registered ram word
    mem_isa_pkg::word_t     load_wdata; // aligned result

    mem_exc_arbiter exc_arbiter_i (
        .op_i         (op_i),
        .cp0_status_i (cp0_status_i),
        .cp0_cause_i  (cp0_cause_i),
        .exc_code_o   (exc_code)
    );

    mem_access_decode access_decode_i (
        .op_i          (op_i),
        .llbit_i       (llbit_i),
        .exc_code_i    (exc_code),
        .cmd_o         (cmd),
        .need_ram_o    (need_ram),
        .llbit_we_o    (llbit_we),
        .llbit_value_o (llbit_value)
    );

    mem_load_align load_align_i (
        .op_i    (op_i),
        .rdata_i (rdata),
        .llbit_i (llbit_i),
        .wdata_o (load_wdata)
    );

    mem_stage_ctrl stage_ctrl_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .need_ram_i  (need_ram),
        .cmd_i       (cmd),
        .ram_ack_i   (ram_ack_i),
        .ram_rdata_i (ram_rdata_i),
        .ack_o       (ack_o),
        .ram_req_o   (ram_req_o),
        .ram_cmd_o   (ram_cmd_o),
        .rdata_o     (rdata)
    );

    // op_i stays stable during ack, so wb can be combinational
    assign wb_o.waddr       = op_i.waddr;
    assign wb_o.reg_we      = op_i.reg_we;
    assign wb_o.wdata       = load_wdata;
    assign wb_o.llbit_we    = llbit_we;
    assign wb_o.llbit_value = llbit_value;
    assign wb_o.exc_code    = exc_code;

endmodule

`default_nettype wire

// ==== mem_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_sva (
    input logic                  clk,
    input logic                  arst_n_i,
    input logic                  ack_o,
    input logic                  ram_req_o,
    input logic                  ram_ack_i,
    input mem_bus_pkg::ram_cmd_t ram_cmd_o
);

    int unsigned fail_cnt = 0; // failures, summed by the testbench

    // command frozen while the ram request is up
    cmd_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_req_o && $past(ram_req_o) |-> $stable(ram_cmd_o))
        else begin
            fail_cnt++;
            $error("ram_cmd_o changed while ram_req_o was high");
        end

    req_held_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_req_o && !ram_ack_i |=> ram_req_o) // no early withdraw
        else begin
            fail_cnt++;
            $error("ram_req_o fell before ram_ack_i");
        end

    reset_low_a: assert property (@(posedge clk) !arst_n_i |-> !ack_o && !ram_req_o)
        else begin
            fail_cnt++;
            $error("ack_o or ram_req_o high during reset");
        end

endmodule

bind mem_stage mem_stage_sva mem_stage_sva_i (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .ack_o     (ack_o),
    .ram_req_o (ram_req_o),
    .ram_ack_i (ram_ack_i),
    .ram_cmd_o (ram_cmd_o)
);

`default_nettype wire

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"
`default_nettype none

module tb_mem_stage;

    logic                  clk;
    logic                  arst_n_i;
    logic                  req_i;
    mem_bus_pkg::mem_op_t  op_i;
    logic                  llbit_i;
    mem_isa_pkg::word_t    cp0_status_i;
    mem_isa_pkg::word_t    cp0_cause_i;
    logic                  ram_ack_i;
    mem_isa_pkg::word_t    ram_rdata_i;
    logic                  ack_o;
    mem_bus_pkg::mem_wb_t  wb_o;
    logic                  ram_req_o;
    mem_bus_pkg::ram_cmd_t ram_cmd_o;

    logic [7:0]            ram_mem [0:63];   // big-endian byte store
    logic [31:0]           seed = 32'hb209;  // lcg state
    int                    errors = 0;
    int                    checks = 0;
    int                    op_cnt = 0;       // ops issued
    int                    done_cnt = 0;     // ack rises seen
    int                    ram_cnt = 0;      // ram requests seen
    int                    ram_wait;         // cycles left before ram ack
    logic                  ram_busy;         // request taken and ack pending
    logic                  ack_seen;
    logic                  exp_need;         // ram access expected
    mem_bus_pkg::ram_cmd_t exp_cmd;
    mem_bus_pkg::mem_wb_t  exp_q [$];        // one entry per op in flight
    mem_bus_pkg::mem_wb_t  exp_wb;
    mem_bus_pkg::mem_wb_t  held_wb;          // wb_o at the ack rise

    mem_stage mem_stage_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .llbit_i      (llbit_i),
        .cp0_status_i (cp0_status_i),
        .cp0_cause_i  (cp0_cause_i),
        .ram_ack_i    (ram_ack_i),
        .ram_rdata_i  (ram_rdata_i),
        .ack_o        (ack_o),
        .wb_o         (wb_o),
        .ram_req_o    (ram_req_o),
        .ram_cmd_o    (ram_cmd_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    function automatic logic [15:0] rand16();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16]; // upper half since low bits are weak
    endfunction

    function automatic mem_isa_pkg::word_t read_word(input mem_isa_pkg::word_t a);
        logic [5:0] base;
        base = {a[5:2], 2'b00};
        return {ram_mem[base], ram_mem[base + 6'd1], ram_mem[base + 6'd2], ram_mem[base + 6'd3]};
    endfunction

    task automatic write_lanes(input mem_bus_pkg::ram_cmd_t c);
        int k;
        for (k = 0; k < 4; k++) begin
            if (c.sel[3 - k]) begin // sel bit 3 is offset 0
                ram_mem[c.addr[5:0] + k] = c.wdata[31 - 8 * k -: 8];
            end
        end
    endtask

    task automatic check_val(input string name, input logic [95:0] exp, input logic [95:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    // expected result from the isa rules
    function automatic void predict(input mem_bus_pkg::mem_op_t o, input logic ll,
                                    input mem_isa_pkg::word_t st, input mem_isa_pkg::word_t ca,
                                    input mem_isa_pkg::word_t mem_word,
                                    output mem_bus_pkg::mem_wb_t wb, output logic need,
                                    output mem_bus_pkg::ram_cmd_t cmd);
        logic [1:0]         ofs;
        logic               irq;
        logic               mis;
        mem_isa_pkg::word_t data;
        logic [7:0]         b;
        logic [15:0]        h;
        ofs = o.addr[1:0];
        irq = (o.inst_addr != 0) && (|(ca[15:8] & st[15:8])) && !st[1] && st[0];
        if (irq) wb.exc_code = mem_isa_pkg::INTERRUPT;
        else if (o.exc[8]) wb.exc_code = mem_isa_pkg::SYSCALL;
        else if (o.exc[9]) wb.exc_code = mem_isa_pkg::INVALID;
        else if (o.exc[10]) wb.exc_code = mem_isa_pkg::TRAP;
        else if (o.exc[11]) wb.exc_code = mem_isa_pkg::OVERFLOW;
        else if (o.exc[12]) wb.exc_code = mem_isa_pkg::ERET;
        else wb.exc_code = mem_isa_pkg::NONE;
        cmd = '0;
        cmd.addr = {o.addr[31:2], 2'b00};
        mis = 1'b0;
        case (o.op)
            mem_isa_pkg::LB, mem_isa_pkg::LBU, mem_isa_pkg::SB: begin
                cmd.sel[2'd3 - ofs] = 1'b1; // lane of the addressed byte
            end
            mem_isa_pkg::LH, mem_isa_pkg::LHU, mem_isa_pkg::SH: begin
                cmd.sel[2'd3 - {ofs[1], 1'b0}] = 1'b1; // pair from offset 0 or 2
                cmd.sel[2'd2 - {ofs[1], 1'b0}] = 1'b1;
                mis = ofs[0];
            end
            mem_isa_pkg::LW, mem_isa_pkg::SW: begin
                cmd.sel = 4'b1111;
                mis = (ofs != 2'd0);
            end
            mem_isa_pkg::LL, mem_isa_pkg::SC: begin
                cmd.sel = 4'b1111;
            end
            default: begin
                cmd.sel = 4'b0000;
            end
        endcase
        case (o.op)
            mem_isa_pkg::SB: cmd.wdata = {4{o.wdata[7:0]}};
            mem_isa_pkg::SH: cmd.wdata = {2{o.wdata[15:0]}};
            mem_isa_pkg::SW, mem_isa_pkg::SC: cmd.wdata = o.wdata;
            default: cmd.wdata = '0;
        endcase
        cmd.we = (o.op == mem_isa_pkg::SB) || (o.op == mem_isa_pkg::SH)
                 || (o.op == mem_isa_pkg::SW) || (o.op == mem_isa_pkg::SC);
        need = (o.op != mem_isa_pkg::NOP) && !mis && !((o.op == mem_isa_pkg::SC) && !ll)
               && (wb.exc_code == mem_isa_pkg::NONE);
        data = need ? mem_word : '0; // skipped access reads as zero
        b = 8'(data >> (24 - 8 * ofs));
        h = 16'(data >> (16 - 16 * ofs[1]));
        case (o.op)
            mem_isa_pkg::LB: wb.wdata = {{24{b[7]}}, b};
            mem_isa_pkg::LBU: wb.wdata = {24'b0, b};
            mem_isa_pkg::LH: wb.wdata = mis ? '0 : {{16{h[15]}}, h};
            mem_isa_pkg::LHU: wb.wdata = mis ? '0 : {16'b0, h};
            mem_isa_pkg::LW: wb.wdata = mis ? '0 : data;
            mem_isa_pkg::LL: wb.wdata = data;
            mem_isa_pkg::SC: wb.wdata = {31'b0, ll};
            default: wb.wdata = o.alu_res;
        endcase
        wb.waddr = o.waddr;
        wb.reg_we = o.reg_we;
        wb.llbit_we = (o.op == mem_isa_pkg::LL) || ((o.op == mem_isa_pkg::SC) && ll);
        wb.llbit_value = (o.op == mem_isa_pkg::LL);
    endfunction

    function automatic mem_bus_pkg::mem_op_t make_op(input mem_isa_pkg::mem_op_e op,
                                                     input mem_isa_pkg::word_t addr,
                                                     input mem_isa_pkg::exc_flags_t exc,
                                                     input mem_isa_pkg::word_t inst);
        mem_bus_pkg::mem_op_t o;
        o.op        = op;
        o.addr      = addr;
        o.wdata     = {rand16(), rand16()};
        o.waddr     = 5'(rand16());
        o.reg_we    = rand16() % 2;
        o.alu_res   = {rand16(), rand16()};
        o.exc       = exc;
        o.inst_addr = inst;
        return o;
    endfunction

    task automatic end_run();
        errors += mem_stage_i.mem_stage_sva_i.fail_cnt; // bound assertion failures
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    // one full four-phase transfer started on a falling edge
    task automatic run_op(input mem_bus_pkg::mem_op_t o);
        int cycles;
        int ram_before;
        predict(o, llbit_i, cp0_status_i, cp0_cause_i, read_word(o.addr), exp_wb, exp_need,
                exp_cmd);
        exp_q.push_back(exp_wb);
        ram_before = ram_cnt;
        op_cnt++;
        op_i  = o;
        req_i = 1'b1;
        cycles = 0;
        while (!ack_o && cycles < `MEM_RAM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack_o) fail_timeout("ack_o to rise");
        if (!exp_need) check_val("ack_o latency", 2, cycles - 1); // edges after req sampled
        repeat (rand16() % 4) @(negedge clk); // late drop of req
        req_i = 1'b0;
        cycles = 0;
        while (ack_o && cycles < `MEM_RAM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack_o) fail_timeout("ack_o to fall");
        check_val("ram_req_o count", exp_need, ram_cnt - ram_before);
        check_val("ack_o count", op_cnt, done_cnt);
        if (exp_wb.llbit_we) llbit_i = exp_wb.llbit_value; // link bit kept outside
    endtask

    // compare at ack rise and check the hold after
    always @(negedge clk) begin
        if (!ack_o) begin
            ack_seen = 1'b0;
        end else if (!ack_seen) begin
            ack_seen = 1'b1;
            done_cnt++;
            held_wb = wb_o;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("ack_o rose with no operation outstanding");
            end
            if (exp_q.size() != 0) begin
                exp_wb = exp_q.pop_front();
                check_val("wb_o.wdata", exp_wb.wdata, wb_o.wdata);
                check_val("wb_o.exc_code", exp_wb.exc_code, wb_o.exc_code);
                check_val("wb_o.waddr", exp_wb.waddr, wb_o.waddr);
                check_val("wb_o.reg_we", exp_wb.reg_we, wb_o.reg_we);
                check_val("wb_o.llbit_we", exp_wb.llbit_we, wb_o.llbit_we);
                check_val("wb_o.llbit_value", exp_wb.llbit_value, wb_o.llbit_value);
            end
        end else begin
            check_val("wb_o held", held_wb, wb_o); // stable while ack high
        end
    end

    // ram slave with random ack delay
    always @(negedge clk) begin
        if (ram_req_o && !ram_ack_i) begin
            if (!ram_busy) begin
                ram_busy = 1'b1;
                ram_cnt++;
                ram_wait = rand16() % 6;
                check_val("ram_cmd_o", exp_cmd, ram_cmd_o);
                assert (exp_need) else begin
                    errors++;
                    $display("ram_req_o rose for an operation that must not reach ram");
                end
            end
            if (ram_wait == 0) begin
                ram_rdata_i = read_word(ram_cmd_o.addr); // old word before any write
                if (ram_cmd_o.we) write_lanes(ram_cmd_o);
                ram_ack_i = 1'b1;
            end else begin
                ram_wait--;
            end
        end else if (!ram_req_o && ram_ack_i) begin
            ram_ack_i = 1'b0;
            ram_busy  = 1'b0;
        end
    end

    initial begin
        mem_isa_pkg::exc_flags_t flags;
        mem_isa_pkg::word_t      inst;
        int                      i;
        int                      c;
        int                      n;
        arst_n_i     = 1'b0;
        req_i        = 1'b0;
        op_i         = '0;
        llbit_i      = 1'b0;
        cp0_status_i = '0;
        cp0_cause_i  = '0;
        ram_ack_i    = 1'b0;
        ram_rdata_i  = '0;
        ram_busy     = 1'b0;
        ram_wait     = 0;
        ack_seen     = 1'b0;
        exp_need     = 1'b0;
        exp_cmd      = '0;
        for (i = 0; i < 64; i++) begin
            ram_mem[i] = 8'(i * 37 + 8'h5b); // every byte differs
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("ack_o", 0, ack_o);
        check_val("ram_req_o", 0, ram_req_o);
        arst_n_i = 1'b1;
        @(negedge clk);
        for (c = 1; c <= 5; c++) begin // lb .. lw at every offset
            for (i = 0; i < 4; i++) begin
                run_op(make_op(mem_isa_pkg::mem_op_e'(8'(c)), 32'h10 + i, '0, 32'h400));
            end
        end
        for (c = 7; c <= 9; c++) begin // sb, sh, sw then read back
            for (i = 0; i < 4; i++) begin
                run_op(make_op(mem_isa_pkg::mem_op_e'(8'(c)), 32'h14 + i, '0, 32'h400));
                run_op(make_op((c == 7) ? mem_isa_pkg::LBU : (c == 8) ? mem_isa_pkg::LHU
                               : mem_isa_pkg::LW, 32'h14 + i, '0, 32'h404));
            end
        end
        run_op(make_op(mem_isa_pkg::LL, 32'h20, '0, 32'h400));
        run_op(make_op(mem_isa_pkg::SC, 32'h20, '0, 32'h404)); // link set so it succeeds
        run_op(make_op(mem_isa_pkg::SC, 32'h20, '0, 32'h408)); // link gone so it fails
        run_op(make_op(mem_isa_pkg::LW, 32'h20, '0, 32'h40c));
        run_op(make_op(mem_isa_pkg::NOP, 32'h0, '0, 32'h410));
        cp0_status_i = 32'h0000_ff01; // ie set with all masks open
        cp0_cause_i  = 32'h0000_0400;
        run_op(make_op(mem_isa_pkg::SW, 32'h24, '0, 32'h400)); // interrupted store
        run_op(make_op(mem_isa_pkg::SW, 32'h24, '0, 32'h0));   // pc zero suppresses the irq
        cp0_status_i = '0;
        for (i = 8; i <= 12; i++) begin // lowest set flag wins
            run_op(make_op(mem_isa_pkg::SB, 32'h28, (32'h1f00 >> i) << i, 32'h400));
        end
        for (n = 0; n < 300; n++) begin
            llbit_i      = rand16() % 2;
            cp0_status_i = {rand16(), rand16()};
            cp0_cause_i  = (rand16() % 4 == 0) ? {rand16(), rand16()} : '0;
            flags        = '0;
            for (i = 8; i <= 12; i++) begin
                flags[i] = (rand16() % 16 == 0); // rare raw flags
            end
            inst = (rand16() % 8 == 0) ? '0 : {rand16(), rand16()};
            run_op(make_op(mem_isa_pkg::mem_op_e'(8'(rand16() % 11)), 32'(rand16() % 64),
                           flags, inst));
            repeat (rand16() % 3) @(negedge clk);
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
mem_isa_pkg.sv
mem_bus_pkg.sv
mem_exc_arbiter.sv
mem_access_decode.sv
mem_load_align.sv
mem_stage_ctrl.sv
mem_stage.sv
mem_stage_sva.sv
tb_mem_stage.sv
